//--- build.f
design/count_pkg.sv
design/lfsr_pkg.sv
design/count_cmd_decoder.sv
design/counter_channel.sv
design/trojan1.sv
design/count_event_collector.sv
design/counter_bank_top.sv
dv/counter_bank_asserts.sv
dv/counter_bank_tb.sv

//--- Bender.yml
package:
  name: counter_bank

sources:
  - design/count_pkg.sv
  - design/lfsr_pkg.sv
  - design/count_cmd_decoder.sv
  - design/counter_channel.sv
  - design/trojan1.sv
  - design/count_event_collector.sv
  - design/counter_bank_top.sv
  - target: simulation
    files:
      - dv/counter_bank_asserts.sv
      - dv/counter_bank_tb.sv

//--- dv/counter_bank_tb.sv
/*
 * Counter bank testbench: clock and reset, cycle-based reference model,
 * directed tests for load, wrap, broadcast and the trigger payload
 */
`timescale 1ns/10ps

module counter_bank_tb
    import count_pkg::*;
#(
    parameter bit TROJAN_EN = 1'b1
);

    localparam int NUM_CHAN = 4;
    localparam int TIMEOUT  = 40;

    logic                clk;
    logic                rst;
    logic                cmd_strobe;
    cmd_op_e             cmd_op;
    chan_idx_t           cmd_chan;
    logic                cmd_broadcast;
    count_t              cmd_data;
    chan_idx_t           read_chan;
    logic                status_clear;
    count_t              read_value;
    logic [NUM_CHAN-1:0] overflow_status;
    logic [NUM_CHAN-1:0] underflow_status;
    logic                irq;

    int errors = 0;
    int checks = 0;
    int seed   = 32'h334312d6;

    // Model decoder stage
    logic [NUM_CHAN-1:0] m_cnt_en;
    logic [NUM_CHAN-1:0] m_cnt_dir;
    logic [NUM_CHAN-1:0] m_load_en;
    count_t              m_load_val;
    // Model channels
    count_t              m_counter [NUM_CHAN];
    logic [23:0]         m_lfsr [NUM_CHAN];
    int                  m_sel [NUM_CHAN];
    logic [3:0]          m_hist [NUM_CHAN];
    count_t              m_cv [NUM_CHAN];
    // History all ones behind each output register, in either build
    logic [NUM_CHAN-1:0] m_cv_trig;
    logic [NUM_CHAN-1:0] m_ovf;
    logic [NUM_CHAN-1:0] m_unf;
    // Model collector
    logic [NUM_CHAN-1:0] m_ovf_st;
    logic [NUM_CHAN-1:0] m_unf_st;
    logic                m_irq;
    count_t              m_read;
    logic                m_read_trig;

    counter_bank_top #(
        .NUM_CHAN (NUM_CHAN),
        .TROJAN_EN(TROJAN_EN)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .cmd_strobe      (cmd_strobe),
        .cmd_op          (cmd_op),
        .cmd_chan        (cmd_chan),
        .cmd_broadcast   (cmd_broadcast),
        .cmd_data        (cmd_data),
        .read_chan       (read_chan),
        .status_clear    (status_clear),
        .read_value      (read_value),
        .overflow_status (overflow_status),
        .underflow_status(underflow_status),
        .irq             (irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Payload applied only by the infected build while the history is all ones
    function automatic count_t payload_mask(logic fired);
        return (TROJAN_EN && fired) ? TROJAN_MASK : count_t'(0);
    endfunction

    // Reference model, stages updated back to front so each reads last cycle
    always @(posedge clk or posedge rst) begin : model
        logic [NUM_CHAN-1:0] target;
        logic [NUM_CHAN-1:0] ovf_next;
        logic [NUM_CHAN-1:0] unf_next;
        logic                trig;
        logic                fb;
        if (rst) begin
            m_cnt_en  = '0;
            m_cnt_dir = '0;
            m_load_en = '0;
            m_load_val = '0;
            for (int c = 0; c < NUM_CHAN; c++) begin
                m_counter[c] = '0;
                m_lfsr[c]    = 24'hDEADBE ^ 24'(c);
                m_sel[c]     = 0;
                m_hist[c]    = '0;
                m_cv[c]      = '0;
            end
            m_cv_trig   = '0;
            m_ovf       = '0;
            m_unf       = '0;
            m_ovf_st    = '0;
            m_unf_st    = '0;
            m_irq       = 1'b0;
            m_read      = '0;
            m_read_trig = 1'b0;
        end else begin
            // Sticky status, a fresh flag beats the clear
            ovf_next = (status_clear ? '0 : m_ovf_st) | m_ovf;
            unf_next = (status_clear ? '0 : m_unf_st) | m_unf;
            m_ovf_st = ovf_next;
            m_unf_st = unf_next;
            m_irq    = |{ovf_next, unf_next};
            m_read      = (read_chan < NUM_CHAN) ? m_cv[read_chan] : '0;
            m_read_trig = (read_chan < NUM_CHAN) ? m_cv_trig[read_chan] : 1'b0;
            for (int c = 0; c < NUM_CHAN; c++) begin
                // Output register with payload
                trig = &m_hist[c];
                m_cv[c]      = m_counter[c] ^ payload_mask(trig);
                m_cv_trig[c] = trig;
                // History shifts every clock
                m_hist[c] = {m_hist[c][2:0], m_lfsr[c][m_sel[c]]};
                m_ovf[c] = 1'b0;
                m_unf[c] = 1'b0;
                if (m_load_en[c]) begin
                    m_counter[c] = m_load_val;
                end else if (m_cnt_en[c] && !m_cnt_dir[c]) begin
                    m_ovf[c]     = (m_counter[c] == 12'hFFF);
                    m_counter[c] = m_counter[c] + 12'd1;
                end else if (m_cnt_en[c]) begin
                    m_unf[c]     = (m_counter[c] == 12'h000);
                    m_counter[c] = m_counter[c] - 12'd1;
                end
                // LFSR taps 23, 17, 14, 1 and pointer step only when counting
                if (m_cnt_en[c]) begin
                    fb = m_lfsr[c][23] ^ m_lfsr[c][17] ^ m_lfsr[c][14] ^ m_lfsr[c][1];
                    m_lfsr[c] = {m_lfsr[c][22:0], fb};
                    m_sel[c]  = (m_sel[c] == 23) ? 0 : m_sel[c] + 1;
                end
            end
            target = '0;
            if (cmd_broadcast) begin
                target = '1;
            end else if (cmd_chan < NUM_CHAN) begin
                target[cmd_chan] = 1'b1;
            end
            m_cnt_en  = (cmd_strobe && cmd_op inside {CMD_UP, CMD_DOWN}) ? target : '0;
            m_cnt_dir = (cmd_strobe && cmd_op == CMD_DOWN) ? target : '0;
            m_load_en = (cmd_strobe && cmd_op == CMD_LOAD) ? target : '0;
            if (cmd_strobe) begin
                m_load_val = cmd_data;
            end
        end
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_with_model();
        check_value("read_value", read_value, m_read);
        check_value("overflow_status", overflow_status, m_ovf_st);
        check_value("underflow_status", underflow_status, m_unf_st);
        check_value("irq", irq, m_irq);
    endtask

    // Closing counts line, then the verdict
    task automatic report_and_finish();
        int total;
        total = errors + DUT.u_asserts.fail_count;
        $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
                 checks, errors, DUT.u_asserts.fail_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic abort_run(string why);
        errors++;
        $display("Timeout: %s", why);
        report_and_finish();
    endtask

    // One strobe per call, so calls in a row give back-to-back commands
    task automatic send_cmd(cmd_op_e op, int chan, bit bcast, count_t data);
        @(posedge clk);
        cmd_strobe    <= 1'b1;
        cmd_op        <= op;
        cmd_chan      <= chan_idx_t'(chan);
        cmd_broadcast <= bcast;
        cmd_data      <= data;
    endtask

    task automatic go_idle();
        @(posedge clk);
        cmd_strobe    <= 1'b0;
        cmd_op        <= CMD_HOLD;
        cmd_broadcast <= 1'b0;
    endtask

    task automatic select_read(int chan);
        @(posedge clk);
        read_chan <= chan_idx_t'(chan);
    endtask

    // Decoder, counter and output register
    task automatic drain_pipeline();
        repeat (3) @(posedge clk);
    endtask

    // Read one idle channel, expected count plus the modeled payload
    task automatic read_channel(int chan, count_t exp_count);
        select_read(chan);
        @(posedge clk);
        @(negedge clk);
        check_value("read_value", read_value, exp_count ^ payload_mask(m_read_trig));
        compare_with_model();
    endtask

    task automatic wait_for_irq();
        int cycles;
        cycles = 0;
        while (irq !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (irq !== 1'b1) begin
            abort_run("irq did not rise after a counter wrap");
        end
    endtask

    task automatic pulse_status_clear();
        @(posedge clk);
        status_clear <= 1'b1;
        @(posedge clk);
        status_clear <= 1'b0;
        @(negedge clk);
        check_value("overflow_status", overflow_status, 0);
        check_value("underflow_status", underflow_status, 0);
        check_value("irq", irq, 0);
        compare_with_model();
    endtask

    // Also covers read_chan values with no channel behind them
    task automatic check_reset_state();
        for (int c = 0; c < 8; c++) begin
            read_channel(c, '0);
            check_value("overflow_status", overflow_status, 0);
            check_value("underflow_status", underflow_status, 0);
            check_value("irq", irq, 0);
        end
    endtask

    task automatic load_and_read_back();
        count_t data;
        for (int c = 0; c < NUM_CHAN; c++) begin
            data = count_t'($random(seed));
            select_read(c);
            send_cmd(CMD_LOAD, c, 1'b0, data);
            go_idle();
            // New value shows up on the third edge after the strobe
            for (int k = 1; k <= 4; k++) begin
                @(negedge clk);
                compare_with_model();
            end
            check_value("read_value", read_value, data ^ payload_mask(m_read_trig));
        end
    endtask

    task automatic count_across_wrap();
        int ch;
        ch = NUM_CHAN - 1;
        send_cmd(CMD_LOAD, ch, 1'b0, 12'd4094);
        repeat (3) send_cmd(CMD_UP, ch, 1'b0, '0);
        go_idle();
        wait_for_irq();
        drain_pipeline();
        read_channel(ch, 12'd1);
        check_value("overflow_status", overflow_status[ch], 1);
        send_cmd(CMD_LOAD, ch, 1'b0, 12'd1);
        repeat (3) send_cmd(CMD_DOWN, ch, 1'b0, '0);
        go_idle();
        drain_pipeline();
        read_channel(ch, 12'd4094);
        check_value("underflow_status", underflow_status[ch], 1);
        check_value("irq", irq, 1);
        pulse_status_clear();
    endtask

    task automatic broadcast_versus_single();
        count_t base;
        count_t exp_count;
        base = count_t'($random(seed));
        send_cmd(CMD_LOAD, 0, 1'b1, base);
        send_cmd(CMD_UP, 2, 1'b0, '0);
        send_cmd(CMD_UP, 2, 1'b0, '0);
        send_cmd(CMD_DOWN, 0, 1'b0, '0);
        send_cmd(CMD_UP, 0, 1'b1, '0);
        // No channel 7 in this bank
        send_cmd(CMD_DOWN, 7, 1'b0, '0);
        send_cmd(CMD_HOLD, 1, 1'b1, '0);
        go_idle();
        drain_pipeline();
        for (int c = 0; c < NUM_CHAN; c++) begin
            exp_count = base + 12'd1;
            if (c == 2) exp_count = exp_count + 12'd2;
            if (c == 0) exp_count = exp_count - 12'd1;
            read_channel(c, exp_count);
        end
    endtask

    task automatic run_trigger_payload();
        int     hits;
        count_t data;
        hits = 0;
        for (int r = 0; r < NUM_CHAN; r++) begin
            data = count_t'($random(seed));
            select_read(r);
            send_cmd(CMD_LOAD, 0, 1'b1, data);
            for (int k = 0; k < 80; k++) begin
                send_cmd((r % 2) ? CMD_DOWN : CMD_UP, 0, 1'b1, '0);
                @(negedge clk);
                compare_with_model();
                if (m_read_trig) hits++;
            end
            go_idle();
        end
        // Runs must reach an all-ones history so the payload rule gets exercised
        check_value("trigger_windows", hits != 0, 1);
    endtask

    initial begin
        rst           = 1'b1;
        cmd_strobe    = 1'b0;
        cmd_op        = CMD_HOLD;
        cmd_chan      = '0;
        cmd_broadcast = 1'b0;
        cmd_data      = '0;
        read_chan     = '0;
        status_clear  = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        check_reset_state();
        load_and_read_back();
        count_across_wrap();
        broadcast_versus_single();
        run_trigger_payload();
        drain_pipeline();
        report_and_finish();
    end

endmodule

//--- dv/counter_bank_asserts.sv
/*
 * Concurrent checks on the counter bank: irq after reset, flag pulses,
 * flag exclusion and sticky status
 */
`timescale 1ns/10ps

module counter_bank_asserts #(
    parameter int NUM_CHAN = 4
) (
    input logic                clk,
    input logic                rst,
    input logic [NUM_CHAN-1:0] overflow_flag,
    input logic [NUM_CHAN-1:0] underflow_flag,
    input logic [NUM_CHAN-1:0] overflow_status,
    input logic [NUM_CHAN-1:0] underflow_status,
    input logic                status_clear,
    input logic                irq
);

    // Running count of failed assertions
    int unsigned fail_count = 0;

    // Nothing pending right out of reset
    irq_after_reset: assert property (@(posedge clk) rst |=> !irq)
        else begin
            $error("irq high in the cycle after reset");
            fail_count++;
        end

    // A wrap flag never stays high two cycles in a row
    flag_single_cycle: assert property (@(posedge clk) disable iff (rst)
        ((overflow_flag & $past(overflow_flag)) |
         (underflow_flag & $past(underflow_flag))) == '0)
        else begin
            $error("wrap flag held longer than one cycle");
            fail_count++;
        end

    // One channel cannot wrap both ways at once
    flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        (overflow_flag & underflow_flag) == '0)
        else begin
            $error("overflow and underflow flags high together");
            fail_count++;
        end

    // Set bits survive any cycle without a clear
    status_sticky: assert property (@(posedge clk) disable iff (rst)
        !status_clear |=>
            ((overflow_status & $past(overflow_status)) == $past(overflow_status)) &&
            ((underflow_status & $past(underflow_status)) == $past(underflow_status)))
        else begin
            $error("status bit dropped without status_clear");
            fail_count++;
        end

endmodule

bind counter_bank_top counter_bank_asserts #(
    .NUM_CHAN(NUM_CHAN)
) u_asserts (
    .clk             (clk),
    .rst             (rst),
    .overflow_flag   (overflow_flag),
    .underflow_flag  (underflow_flag),
    .overflow_status (overflow_status),
    .underflow_status(underflow_status),
    .status_clear    (status_clear),
    .irq             (irq)
);

//--- design/counter_bank_top.sv
/*
 * Counter bank: command decoder, NUM_CHAN channels each with a trojan1
 * detector, and the event collector
 */
`timescale 1ns/10ps

module counter_bank_top
    import count_pkg::*;
    import lfsr_pkg::*;
#(
    parameter int NUM_CHAN  = 4,     // 1 to 8
    parameter bit TROJAN_EN = 1'b1   // 0 builds the clean bank
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_strobe,
    input  cmd_op_e             cmd_op,
    input  chan_idx_t           cmd_chan,
    input  logic                cmd_broadcast,
    input  count_t              cmd_data,
    input  chan_idx_t           read_chan,
    input  logic                status_clear,
    output count_t              read_value,
    output logic [NUM_CHAN-1:0] overflow_status,
    output logic [NUM_CHAN-1:0] underflow_status,
    output logic                irq
);

    // Decoder to channels
    logic   [NUM_CHAN-1:0] count_enable;
    logic   [NUM_CHAN-1:0] count_direction;
    logic   [NUM_CHAN-1:0] load_enable;
    count_t                load_value;

    // Channels to collector
    count_t [NUM_CHAN-1:0] count_value;
    logic   [NUM_CHAN-1:0] overflow_flag;
    logic   [NUM_CHAN-1:0] underflow_flag;

    // Channel and trigger detector pairs
    logic   [NUM_CHAN-1:0] trojan_r1;
    logic   [NUM_CHAN-1:0] trojan_trigger;

    count_cmd_decoder #(
        .NUM_CHAN(NUM_CHAN)
    ) u_decoder (
        .clk            (clk),
        .rst            (rst),
        .cmd_strobe     (cmd_strobe),
        .cmd_op         (cmd_op),
        .cmd_chan       (cmd_chan),
        .cmd_broadcast  (cmd_broadcast),
        .cmd_data       (cmd_data),
        .count_enable   (count_enable),
        .count_direction(count_direction),
        .load_enable    (load_enable),
        .load_value     (load_value)
    );

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        // Distinct seed per channel
        counter_channel #(
            .R1_INIT  (R1_BASE_SEED ^ LFSR_W'(i)),
            .TROJAN_EN(TROJAN_EN)
        ) u_channel (
            .clk            (clk),
            .rst            (rst),
            .count_enable   (count_enable[i]),
            .count_direction(count_direction[i]),
            .load_enable    (load_enable[i]),
            .load_value     (load_value),
            .trojan_trigger (trojan_trigger[i]),
            .trojan_r1      (trojan_r1[i]),
            .count_value    (count_value[i]),
            .overflow_flag  (overflow_flag[i]),
            .underflow_flag (underflow_flag[i])
        );

        trojan1 u_trojan (
            .clk    (clk),
            .rst    (rst),
            .r1     (trojan_r1[i]),
            .trigger(trojan_trigger[i])
        );
    end

    count_event_collector #(
        .NUM_CHAN(NUM_CHAN)
    ) u_collector (
        .clk             (clk),
        .rst             (rst),
        .overflow_flag   (overflow_flag),
        .underflow_flag  (underflow_flag),
        .count_value     (count_value),
        .read_chan       (read_chan),
        .status_clear    (status_clear),
        .overflow_status (overflow_status),
        .underflow_status(underflow_status),
        .irq             (irq),
        .read_value      (read_value)
    );

endmodule

//--- design/count_event_collector.sv
/*
 * Event collector: sticky wrap status, level interrupt, channel read-back
 */
`timescale 1ns/10ps

module count_event_collector
    import count_pkg::*;
#(
    parameter int NUM_CHAN = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic   [NUM_CHAN-1:0]       overflow_flag,
    input  logic   [NUM_CHAN-1:0]       underflow_flag,
    input  count_t [NUM_CHAN-1:0]       count_value,
    input  chan_idx_t                   read_chan,
    input  logic                        status_clear,
    output logic   [NUM_CHAN-1:0]       overflow_status,
    output logic   [NUM_CHAN-1:0]       underflow_status,
    output logic                        irq,
    output count_t                      read_value
);

    // Next status, new flags beat a clear on the same edge
    logic [NUM_CHAN-1:0] ovf_status_d;
    logic [NUM_CHAN-1:0] unf_status_d;

    // Read-back mux output
    count_t read_sel;

    assign ovf_status_d = (status_clear ? '0 : overflow_status) | overflow_flag;
    assign unf_status_d = (status_clear ? '0 : underflow_status) | underflow_flag;

    // irq follows the next status so it rises with the status bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            overflow_status  <= '0;
            underflow_status <= '0;
            irq              <= 1'b0;
        end else begin
            overflow_status  <= ovf_status_d;
            underflow_status <= unf_status_d;
            irq              <= |{ovf_status_d, unf_status_d};
        end
    end

    // Unpopulated channel reads as 0
    always_comb begin
        read_sel = '0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (read_chan == chan_idx_t'(i)) begin
                read_sel = count_value[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_value <= '0;
        end else begin
            read_value <= read_sel;
        end
    end

endmodule

//--- design/trojan1.sv
/*
 * Trigger detector on the LFSR bit stream
 */
`timescale 1ns/10ps

module trojan1
    import lfsr_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic r1,
    output logic trigger
);

    // Last HIST_W samples of r1, newest in bit 0
    hist_t history;

    // Shift every clock, not only on counting cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history <= '0;
        end else begin
            history <= {history[HIST_W-2:0], r1};
        end
    end

    // Fires while the whole window is ones
    assign trigger = &history;

endmodule

//--- design/counter_channel.sv
/*
 * Counter channel: LFSR with rotating bit pointer, 12-bit up/down core,
 * wrap flags and the output register carrying the trojan payload
 */
`timescale 1ns/10ps

module counter_channel
    import count_pkg::*;
    import lfsr_pkg::*;
#(
    parameter lfsr_t R1_INIT   = R1_BASE_SEED,
    parameter bit    TROJAN_EN = 1'b1
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   count_enable,
    input  logic   count_direction,  // 1 counts down
    input  logic   load_enable,
    input  count_t load_value,
    input  logic   trojan_trigger,
    output logic   trojan_r1,
    output count_t count_value,
    output logic   overflow_flag,
    output logic   underflow_flag
);

    // LFSR state and bit pointer
    lfsr_t   r1_lfsr;
    bitsel_t r1_bit_select;

    // Counter core
    count_t counter;
    logic   at_min;
    logic   at_max;

    // Payload selection
    count_t out_mask;

    // LFSR and pointer advance only on counting cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r1_lfsr       <= R1_INIT;
            r1_bit_select <= '0;
        end else if (count_enable) begin
            r1_lfsr <= lfsr_next(r1_lfsr);
            if (r1_bit_select == BITSEL_MAX) begin
                r1_bit_select <= '0;
            end else begin
                r1_bit_select <= r1_bit_select + bitsel_t'(1);
            end
        end
    end

    // Selected bit goes out to the trigger detector
    assign trojan_r1 = r1_lfsr[r1_bit_select];

    // Range ends
    assign at_min = (counter == '0);
    assign at_max = (counter == COUNT_MAX);

    // Load wins over counting
    // Flags default low so each wrap gives a one-cycle pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter        <= '0;
            overflow_flag  <= 1'b0;
            underflow_flag <= 1'b0;
        end else begin
            overflow_flag  <= 1'b0;
            underflow_flag <= 1'b0;
            if (load_enable) begin
                counter <= load_value;
            end else if (count_enable) begin
                if (!count_direction) begin
                    counter <= counter + count_t'(1);
                    // Up past max wraps to 0
                    overflow_flag <= at_max;
                end else begin
                    counter <= counter - count_t'(1);
                    // Down past 0 wraps to max
                    underflow_flag <= at_min;
                end
            end
        end
    end

    // Clean build ignores the trigger
    assign out_mask = (TROJAN_EN && trojan_trigger) ? TROJAN_MASK : '0;

    // Registered output, one cycle behind the core
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_value <= '0;
        end else begin
            count_value <= counter ^ out_mask;
        end
    end

endmodule

//--- design/count_cmd_decoder.sv
/*
 * Command decoder: one strobe in, per-channel load and count controls out
 */
`timescale 1ns/10ps

module count_cmd_decoder
    import count_pkg::*;
#(
    parameter int NUM_CHAN = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_strobe,
    input  cmd_op_e             cmd_op,
    input  chan_idx_t           cmd_chan,
    input  logic                cmd_broadcast,
    input  count_t              cmd_data,
    output logic [NUM_CHAN-1:0] count_enable,
    output logic [NUM_CHAN-1:0] count_direction,
    output logic [NUM_CHAN-1:0] load_enable,
    output count_t              load_value
);

    // Channels addressed by the current command
    logic [NUM_CHAN-1:0] target;

    // Next-cycle control vectors
    logic [NUM_CHAN-1:0] count_en_d;
    logic [NUM_CHAN-1:0] count_dir_d;
    logic [NUM_CHAN-1:0] load_en_d;

    // All ones on broadcast, else one-hot
    // Out-of-range index matches no bit
    always_comb begin
        target = '0;
        if (cmd_broadcast) begin
            target = '1;
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (cmd_chan == chan_idx_t'(i)) begin
                    target[i] = 1'b1;
                end
            end
        end
    end

    // Opcode to control vectors
    always_comb begin
        count_en_d  = '0;
        count_dir_d = '0;
        load_en_d   = '0;
        if (cmd_strobe) begin
            case (cmd_op)
                CMD_LOAD: load_en_d = target;
                CMD_UP:   count_en_d = target;
                CMD_DOWN: begin
                    count_en_d  = target;
                    count_dir_d = target;
                end
                default: ;  // CMD_HOLD leaves everything idle
            endcase
        end
    end

    // Controls live for one cycle only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_enable    <= '0;
            count_direction <= '0;
            load_enable     <= '0;
        end else begin
            count_enable    <= count_en_d;
            count_direction <= count_dir_d;
            load_enable     <= load_en_d;
        end
    end

    // Shared load payload, captured with the strobe
    always_ff @(posedge clk) begin
        if (cmd_strobe) begin
            load_value <= cmd_data;
        end
    end

endmodule

//--- design/lfsr_pkg.sv
/*
 * LFSR and trigger history widths, base seed
 * LFSR state typedefs and next-state function
 */
package lfsr_pkg;

    // LFSR state
    localparam int LFSR_W = 24;

    typedef logic [LFSR_W-1:0] lfsr_t;

    // Bit pointer walks all 24 LFSR bits
    typedef logic [4:0] bitsel_t;

    // Last pointer position before wrapping to 0
    localparam bitsel_t BITSEL_MAX = bitsel_t'(LFSR_W - 1);

    // Channel seeds are this value XOR the channel index
    localparam lfsr_t R1_BASE_SEED = 24'hDEADBE;

    // Trigger history depth
    localparam int HIST_W = 4;

    typedef logic [HIST_W-1:0] hist_t;

    // Fibonacci step, taps 23, 17, 14 and 1
    function automatic lfsr_t lfsr_next(lfsr_t state);
        logic fb;
        fb = state[23] ^ state[17] ^ state[14] ^ state[1];
        return {state[LFSR_W-2:0], fb};
    endfunction

endpackage

//--- design/count_pkg.sv
/*
 * Counter datapath widths and value typedefs
 * Trojan payload mask and command opcode encoding
 */
package count_pkg;

    // Counter datapath
    localparam int COUNT_W = 12;

    // Count, load or read-back value
    typedef logic [COUNT_W-1:0] count_t;

    // Top of the full counting range, wrap point for up and down
    localparam count_t COUNT_MAX = {COUNT_W{1'b1}};

    // Payload inverts the low nibble of the output register
    localparam count_t TROJAN_MASK = count_t'(12'h00F);

    // Channel addressing, up to 8 channels
    localparam int MAX_CHAN_W = 3;

    typedef logic [MAX_CHAN_W-1:0] chan_idx_t;

    // Command opcodes
    typedef enum logic [1:0] {
        CMD_HOLD = 2'b00,
        CMD_LOAD = 2'b01,
        CMD_UP   = 2'b10,
        CMD_DOWN = 2'b11
    } cmd_op_e;

endpackage
